//--- source/ingress_pkg.sv
/*
 * Ingress shared definitions
 * Widths and constants used across the receive stage, the word buffer
 * and the credit scheduler
 */

package ingress_pkg;

  // ==================================================
  // Datapath widths
  // ==================================================

  // Payload word size in bits and bytes
  localparam int IGR_DATA_W     = 64;
  localparam int IGR_DATA_BYTES = IGR_DATA_W / 8;

  // Number of traffic classes on the CDI link
  localparam int IGR_NUM_TC = 8;

  // ==================================================
  // Typedefs
  // ==================================================

  // CDI payload word
  typedef logic [IGR_DATA_W-1:0] igr_data_t;

  // One even parity bit per data byte
  typedef logic [IGR_DATA_BYTES-1:0] igr_ecc_t;

  // Source port number
  typedef logic [5:0] igr_port_t;

  // Traffic class, indexes the xoff vector
  typedef logic [$clog2(IGR_NUM_TC)-1:0] igr_tc_t;

  // PFC xoff, one bit per class
  typedef logic [IGR_NUM_TC-1:0] igr_tc_mask_t;

  // Statistics counter, saturates at all ones
  typedef logic [15:0] igr_count_t;

endpackage

//--- source/igr_push_if.sv
/*
 * Push bus from the CDI receive stage into the word buffer
 * One strobe per checked word, no back-pressure
 */

`timescale 1ns/1ps

interface igr_push_if;

  // Write strobe, one cycle per good word
  logic                   push;
  // Word payload and its tags
  ingress_pkg::igr_data_t data;
  ingress_pkg::igr_port_t port;
  ingress_pkg::igr_tc_t   tc;

  // Receive stage side
  modport src (output push, output data, output port, output tc);

  // Buffer side, samples on the edge with push high
  modport snk (input push, input data, input port, input tc);

endinterface

//--- source/igr_pop_if.sv
/*
 * Pop bus between the word buffer and the credit scheduler
 * Buffer shows its head entry, scheduler strobes pop to remove it
 */

`timescale 1ns/1ps

interface igr_pop_if;

  // Head entry, combinational from the buffer
  logic                   not_empty;
  ingress_pkg::igr_data_t head_data;
  ingress_pkg::igr_port_t head_port;
  ingress_pkg::igr_tc_t   head_tc;
  // Remove the head at the next edge
  logic                   pop;

  // Buffer side
  modport src (output not_empty, output head_data, output head_port,
               output head_tc, input pop);

  // Scheduler side
  modport snk (input not_empty, input head_data, input head_port,
               input head_tc, output pop);

endinterface

//--- source/igr_cdi_rx.sv
/*
 * CDI receive stage
 * Registers each valid input word, checks the per-byte parity against
 * the received ECC field, pushes good words and counts bad ones
 */

`timescale 1ns/1ps

module igr_cdi_rx (
  input  logic                    primary_clock,
  input  logic                    rst_n,
  input  logic                    data_valid,
  input  ingress_pkg::igr_port_t  port_num,
  input  ingress_pkg::igr_data_t  data_w_ecc,
  input  ingress_pkg::igr_ecc_t   ecc,
  input  ingress_pkg::igr_tc_t    flow_control_tc,
  output ingress_pkg::igr_count_t ecc_err_count,
  igr_push_if.src                 push_bus
);

  // ==================================================
  // Parity helper
  // ==================================================

  // Even parity of each byte, bit i covers byte i
  function automatic ingress_pkg::igr_ecc_t calc_parity(input ingress_pkg::igr_data_t d);
    ingress_pkg::igr_ecc_t p;
    for (int i = 0; i < ingress_pkg::IGR_DATA_BYTES; i++) begin
      p[i] = ^d[8*i +: 8];
    end
    return p;
  endfunction

  // Input capture registers
  logic                   valid_q;
  ingress_pkg::igr_data_t data_q;
  ingress_pkg::igr_ecc_t  ecc_q;
  ingress_pkg::igr_port_t port_q;
  ingress_pkg::igr_tc_t   tc_q;

  // Check result on the captured word
  logic ecc_ok;

  // ==================================================
  // Input stage
  // ==================================================

  // Valid flag is control state
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= data_valid;
    end
  end

  // Payload only loads on a valid beat
  always_ff @(posedge primary_clock) begin
    if (data_valid) begin
      data_q <= data_w_ecc;
      ecc_q  <= ecc;
      port_q <= port_num;
      tc_q   <= flow_control_tc;
    end
  end

  // Recomputed parity must match the sender's field
  assign ecc_ok = (calc_parity(data_q) == ecc_q);

  // ==================================================
  // Push to buffer
  // ==================================================

  // Good word goes out the cycle after capture
  assign push_bus.push = valid_q && ecc_ok;
  assign push_bus.data = data_q;
  assign push_bus.port = port_q;
  assign push_bus.tc   = tc_q;

  // Bad words are dropped here and counted
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      ecc_err_count <= '0;
    end else if (valid_q && !ecc_ok && (ecc_err_count != '1)) begin
      // Hold at all ones once saturated
      ecc_err_count <= ecc_err_count + 1'b1;
    end
  end

endmodule

//--- source/igr_word_fifo.sv
/*
 * Ingress word buffer
 * Show-ahead circular FIFO, drops and counts pushes that find it full
 */

`timescale 1ns/1ps

module igr_word_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    primary_clock,
  input  logic                    rst_n,
  output ingress_pkg::igr_count_t drop_count,
  igr_push_if.snk                 push_bus,
  igr_pop_if.src                  pop_bus
);

  // Pointer and occupancy widths
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Storage, one entry per word
  ingress_pkg::igr_data_t mem_data [FIFO_DEPTH];
  ingress_pkg::igr_port_t mem_port [FIFO_DEPTH];
  ingress_pkg::igr_tc_t   mem_tc   [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic do_push;
  logic do_pop;

  // ==================================================
  // Status and qualified strobes
  // ==================================================

  assign full = (count == CNT_W'(FIFO_DEPTH));

  // Pop only ever removes a real entry
  assign do_pop = pop_bus.pop && pop_bus.not_empty;

  // Full buffer still accepts if the head leaves this cycle
  assign do_push = push_bus.push && (!full || do_pop);

  // Head entry straight from the array
  assign pop_bus.not_empty = (count != '0);
  assign pop_bus.head_data = mem_data[rd_ptr];
  assign pop_bus.head_port = mem_port[rd_ptr];
  assign pop_bus.head_tc   = mem_tc[rd_ptr];

  // ==================================================
  // Storage and pointers
  // ==================================================

  always_ff @(posedge primary_clock) begin
    if (do_push) begin
      mem_data[wr_ptr] <= push_bus.data;
      mem_port[wr_ptr] <= push_bus.port;
      mem_tc[wr_ptr]   <= push_bus.tc;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Overflow drops, saturating
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (push_bus.push && !do_push && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

//--- source/igr_credit_sched.sv
/*
 * Credit scheduler
 * Releases the buffer head when a downstream credit is free and its
 * traffic class is not paused, then registers the departing word
 */

`timescale 1ns/1ps

module igr_credit_sched #(
  parameter int MAX_CREDITS = 4
) (
  input  logic                      primary_clock,
  input  logic                      rst_n,
  input  ingress_pkg::igr_tc_mask_t pfc_xoff,
  input  logic                      au_credits,
  output logic                      out_valid,
  output ingress_pkg::igr_data_t    out_data,
  output ingress_pkg::igr_port_t    out_port,
  output ingress_pkg::igr_tc_t      out_tc,
  igr_pop_if.snk                    pop_bus
);

  // Counter must hold 0 through MAX_CREDITS
  localparam int CRD_W = $clog2(MAX_CREDITS + 1);

  // Head blocked by PFC or free to go
  typedef enum logic {
    IDLE,
    PAUSED
  } sched_state_t;

  sched_state_t state;
  sched_state_t state_nxt;

  logic [CRD_W-1:0] credits;
  logic             credit_avail;
  logic             head_paused;

  // ==================================================
  // Release decision
  // ==================================================

  assign credit_avail = (credits != '0);

  // Xoff bit selected by the head's class
  assign head_paused = pfc_xoff[pop_bus.head_tc];

  // Whole queue waits behind a paused head
  assign pop_bus.pop = pop_bus.not_empty && credit_avail && !head_paused;

  // ==================================================
  // Credit counter
  // ==================================================

  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      credits <= CRD_W'(MAX_CREDITS);
    end else if (pop_bus.pop && !au_credits) begin
      credits <= credits - 1'b1;
    end else if (au_credits && !pop_bus.pop && (credits != CRD_W'(MAX_CREDITS))) begin
      // Returns beyond the ceiling are ignored
      credits <= credits + 1'b1;
    end
  end

  // ==================================================
  // Pause tracking FSM
  // ==================================================

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (pop_bus.not_empty && head_paused) state_nxt = PAUSED;
      end
      PAUSED: begin
        // Leave on xoff release or when the head drains
        if (!(pop_bus.not_empty && head_paused)) state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ==================================================
  // Output stage
  // ==================================================

  // One-cycle valid per released word
  always_ff @(posedge primary_clock) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop_bus.pop;
    end
  end

  // Payload captured at the pop edge
  always_ff @(posedge primary_clock) begin
    if (pop_bus.pop) begin
      out_data <= pop_bus.head_data;
      out_port <= pop_bus.head_port;
      out_tc   <= pop_bus.head_tc;
    end
  end

endmodule

//--- source/ingress_top.sv
/*
 * Ingress port top level
 * CDI receive check, word buffer and credit scheduler in one datapath
 */

`timescale 1ns/1ps

module ingress_top #(
  parameter int FIFO_DEPTH  = 8,
  parameter int MAX_CREDITS = 4
) (
  input  logic                      primary_clock,
  input  logic                      rst_n,
  // CDI receive word stream
  input  logic                      data_valid,
  input  ingress_pkg::igr_port_t    port_num,
  input  ingress_pkg::igr_data_t    data_w_ecc,
  input  ingress_pkg::igr_ecc_t     ecc,
  input  ingress_pkg::igr_tc_t      flow_control_tc,
  // Downstream flow control
  input  ingress_pkg::igr_tc_mask_t pfc_xoff,
  input  logic                      au_credits,
  // Forwarded words
  output logic                      out_valid,
  output ingress_pkg::igr_data_t    out_data,
  output ingress_pkg::igr_port_t    out_port,
  output ingress_pkg::igr_tc_t      out_tc,
  // Statistics
  output ingress_pkg::igr_count_t   ecc_err_count,
  output ingress_pkg::igr_count_t   drop_count
);

  // ==================================================
  // Internal buses
  // ==================================================

  // Receive stage into buffer
  igr_push_if push_bus ();
  // Buffer head to scheduler
  igr_pop_if  pop_bus ();

  // Parity check and push
  igr_cdi_rx i_cdi_rx (
    .primary_clock   (primary_clock),
    .rst_n           (rst_n),
    .data_valid      (data_valid),
    .port_num        (port_num),
    .data_w_ecc      (data_w_ecc),
    .ecc             (ecc),
    .flow_control_tc (flow_control_tc),
    .ecc_err_count   (ecc_err_count),
    .push_bus        (push_bus.src)
  );

  // Single shared queue
  igr_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_word_fifo (
    .primary_clock (primary_clock),
    .rst_n         (rst_n),
    .drop_count    (drop_count),
    .push_bus      (push_bus.snk),
    .pop_bus       (pop_bus.src)
  );

  // Credit and PFC gating, output register
  igr_credit_sched #(
    .MAX_CREDITS (MAX_CREDITS)
  ) i_credit_sched (
    .primary_clock (primary_clock),
    .rst_n         (rst_n),
    .pfc_xoff      (pfc_xoff),
    .au_credits    (au_credits),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_port      (out_port),
    .out_tc        (out_tc),
    .pop_bus       (pop_bus.snk)
  );

endmodule

//--- verif/ingress_tests.svh
/*
 * Directed ingress tests
 * One task per behavior, each drives the DUT and checks the result
 */

// Quiet outputs and clear counters after reset
task automatic test_reset_state();
  test_name = "reset_state";
  compare("out_valid", 64'(0), 64'(out_valid));
  compare("ecc_err_count", 64'(0), 64'(ecc_err_count));
  compare("drop_count", 64'(0), 64'(drop_count));
  idle(10);
  compare("words out with no input", 64'(0), 64'(out_count));
endtask

task automatic test_passthrough();
  int r;
  int latency;
  test_name = "passthrough";
  // Lone word, out two edges after its sampling edge
  send_random(3'd4, 1'b0, 1'b1);
  while (!out_valid) @(negedge primary_clock);
  latency = cycles - last_drive_cycle - 1;
  compare("latency", 64'(2), 64'(latency));
  drain_with_credits();
  for (int i = 0; i < 20; i++) begin
    r = $random(seed);
    send_random(r[2:0], 1'b0, 1'b1);
    drain_with_credits();
  end
endtask

task automatic test_ecc_drop();
  int r;
  int bad;
  test_name = "ecc_drop";
  bad = 0;
  for (int i = 0; i < 9; i++) begin
    r = $random(seed);
    // every third word has one flipped check bit
    if (i % 3 == 1) begin
      send_random(r[2:0], 1'b1, 1'b1);
      bad++;
    end else begin
      send_random(r[2:0], 1'b0, 1'b1);
    end
  end
  drain_with_credits();
  // Only corrupted words so far are the ones sent here
  compare("ecc_err_count", 64'(bad), 64'(ecc_err_count));
endtask

task automatic test_credit_limit();
  int base;
  test_name = "credit_limit";
  base = out_count;
  // No returns, only the held credits are spent
  repeat (6) send_random(3'd1, 1'b0, 1'b1);
  wait (out_count >= base + MAX_CREDITS);
  idle(10);
  compare("words out with no returns", 64'(base + MAX_CREDITS), 64'(out_count));
  pulse_credit(1'b1);
  pulse_credit(1'b1);
  wait (out_count >= base + 6);
  idle(5);
  compare("words out after two returns", 64'(base + 6), 64'(out_count));
  // Refill to the ceiling, then one return too many
  repeat (MAX_CREDITS) pulse_credit(1'b1);
  pulse_credit(1'b0);
  base = out_count;
  repeat (5) send_random(3'd6, 1'b0, 1'b1);
  wait (out_count >= base + MAX_CREDITS);
  idle(10);
  compare("words out at full credit", 64'(base + MAX_CREDITS), 64'(out_count));
  drain_with_credits();
endtask

// Paused head blocks later classes too
task automatic test_pfc_pause();
  int base;
  test_name = "pfc_pause";
  base = out_count;
  pfc_xoff = 8'h04;
  send_random(3'd2, 1'b0, 1'b1);
  send_random(3'd5, 1'b0, 1'b1);
  send_random(3'd1, 1'b0, 1'b1);
  idle(12);
  compare("words out while paused", 64'(base), 64'(out_count));
  pfc_xoff = '0;
  drain_with_credits();
endtask

task automatic test_overflow();
  test_name = "overflow";
  // Spend all credits so the buffer only fills
  repeat (MAX_CREDITS) send_random(3'd0, 1'b0, 1'b1);
  wait (out_count >= expected_total);
  idle(2);
  for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
    send_random(3'd3, 1'b0, i < FIFO_DEPTH);
  end
  idle(3);
  // Earlier tests never fill the buffer, so the three extra words are all
  compare("drop_count", 64'(3), 64'(drop_count));
  drain_with_credits();
  idle(10);
endtask

//--- verif/ingress_tb.sv
/*
 * Ingress port testbench
 * Clock, reset, reference queue, output monitor and run timeout
 */

`timescale 1ns/1ps

module ingress_tb;

  localparam int FIFO_DEPTH     = 8;
  localparam int MAX_CREDITS    = 4;
  // Roughly four times the summed test lengths
  localparam int TIMEOUT_CYCLES = 2000;

  logic                      primary_clock = 1'b0;
  logic                      rst_n;
  logic                      data_valid;
  ingress_pkg::igr_port_t    port_num;
  ingress_pkg::igr_data_t    data_w_ecc;
  ingress_pkg::igr_ecc_t     ecc;
  ingress_pkg::igr_tc_t      flow_control_tc;
  ingress_pkg::igr_tc_mask_t pfc_xoff;
  logic                      au_credits;
  logic                      out_valid;
  ingress_pkg::igr_data_t    out_data;
  ingress_pkg::igr_port_t    out_port;
  ingress_pkg::igr_tc_t      out_tc;
  ingress_pkg::igr_count_t   ecc_err_count;
  ingress_pkg::igr_count_t   drop_count;

  // Words due at the output, oldest first
  ingress_pkg::igr_data_t exp_data[$];
  ingress_pkg::igr_port_t exp_port[$];
  ingress_pkg::igr_tc_t   exp_tc[$];

  int    seed;
  int    errors;
  int    cycles;
  // Words seen at the output and credits handed back for them
  int    out_count;
  int    returned;
  int    expected_total;
  int    last_drive_cycle;
  string test_name;

  ingress_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MAX_CREDITS (MAX_CREDITS)
  ) i_dut (.*);

  always #5 primary_clock = ~primary_clock;

  // ==================================================
  // Cycle count and timeout
  // ==================================================

  always @(posedge primary_clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d words never came out", cycles, exp_data.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ==================================================
  // Helpers
  // ==================================================

  // Even parity per byte, built straight from the byte slices
  function automatic ingress_pkg::igr_ecc_t byte_parity(input ingress_pkg::igr_data_t d);
    return {^d[63:56], ^d[55:48], ^d[47:40], ^d[39:32],
            ^d[31:24], ^d[23:16], ^d[15:8], ^d[7:0]};
  endfunction

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge primary_clock);
  endtask

  // One word for one cycle, optionally with a single bad check bit
  task automatic send_word(input ingress_pkg::igr_data_t data, input ingress_pkg::igr_port_t port,
                           input ingress_pkg::igr_tc_t tc, input bit corrupt, input bit keep);
    ingress_pkg::igr_ecc_t flip;
    int r;
    r = $random(seed);
    flip = corrupt ? (ingress_pkg::igr_ecc_t'(1) << r[2:0]) : '0;
    @(negedge primary_clock);
    data_valid      = 1'b1;
    data_w_ecc      = data;
    ecc             = byte_parity(data) ^ flip;
    port_num        = port;
    flow_control_tc = tc;
    last_drive_cycle = cycles;
    if (keep && !corrupt) begin
      exp_data.push_back(data);
      exp_port.push_back(port);
      exp_tc.push_back(tc);
      expected_total++;
    end
    @(negedge primary_clock);
    data_valid = 1'b0;
  endtask

  task automatic send_random(input ingress_pkg::igr_tc_t tc, input bit corrupt, input bit keep);
    int hi;
    int lo;
    int p;
    hi = $random(seed);
    lo = $random(seed);
    p  = $random(seed);
    send_word({hi, lo}, p[5:0], tc, corrupt, keep);
  endtask

  // Single credit return, uncounted when it lands on a full counter
  task automatic pulse_credit(input bit counted);
    @(negedge primary_clock);
    au_credits = 1'b1;
    if (counted) returned++;
    @(negedge primary_clock);
    au_credits = 1'b0;
  endtask

  // Hand back one credit per output until every due word is out
  task automatic drain_with_credits();
    while ((out_count < expected_total) || (returned < out_count)) begin
      @(negedge primary_clock);
      if (returned < out_count) begin
        au_credits = 1'b1;
        returned++;
      end else begin
        au_credits = 1'b0;
      end
    end
    @(negedge primary_clock);
    au_credits = 1'b0;
  endtask

  `include "ingress_tests.svh"

  // Output monitor against the reference queue
  always @(negedge primary_clock) begin
    if (rst_n && out_valid) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("Error in %s: a word came out when none was expected", test_name);
      end else begin
        compare("data", exp_data.pop_front(), out_data);
        compare("port", 64'(exp_port.pop_front()), 64'(out_port));
        compare("tc", 64'(exp_tc.pop_front()), 64'(out_tc));
      end
      out_count++;
    end
  end

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    seed             = 32'h8262;
    errors           = 0;
    cycles           = 0;
    out_count        = 0;
    returned         = 0;
    expected_total   = 0;
    last_drive_cycle = 0;
    test_name        = "setup";
    rst_n            = 1'b0;
    data_valid       = 1'b0;
    port_num         = '0;
    data_w_ecc       = '0;
    ecc              = '0;
    flow_control_tc  = '0;
    pfc_xoff         = '0;
    au_credits       = 1'b0;
    repeat (2) @(negedge primary_clock);
    rst_n = 1'b1;
    test_reset_state();
    test_passthrough();
    test_ecc_drop();
    test_credit_limit();
    test_pfc_pause();
    test_overflow();
    $display("Run complete: %0d words out, %0d errors", out_count, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- ingress.f
+incdir+verif
source/ingress_pkg.sv
source/igr_push_if.sv
source/igr_pop_if.sv
source/igr_cdi_rx.sv
source/igr_word_fifo.sv
source/igr_credit_sched.sv
source/ingress_top.sv
verif/ingress_tb.sv

//--- Makefile
# Verilator build and run for the ingress port

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := ingress_tb
FILELIST  := ingress.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

# A crashed run is logged as a failure too
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
